// File: verilog/packing_pkg.sv
// ======================================================================
// tile mover shared definitions
// grid and tile sizes, AXI channel payloads, buffer write port and
// the state encodings of the sequencer and both burst engines
// ======================================================================
package packing_pkg;

    // ==================================================================
    // grid, tile and bus geometry
    // ==================================================================
    localparam int H              = 24;
    localparam int P              = 64;
    localparam int H_TILE         = 12;
    localparam int P_TILE         = 16;
    localparam int WORD_W         = 16;
    localparam int ADDR_W         = 64;
    localparam int DATA_W         = 128;
    localparam int WORDS_PER_BEAT = DATA_W / WORD_W;
    localparam int NUM_TILE_H     = H / H_TILE;
    localparam int NUM_TILE_P     = P / P_TILE;
    localparam int TILE_WORDS     = H_TILE * P_TILE;
    localparam int BEATS_PER_TILE = TILE_WORDS / WORDS_PER_BEAT;
    localparam int TILE_BYTES     = TILE_WORDS * WORD_W / 8;
    // AXI length field counts beats minus one
    localparam int BURST_LEN      = BEATS_PER_TILE - 1;

    // vector types
    typedef logic [ADDR_W-1:0]                     addr_t;
    // word 0 sits in the low bits
    typedef logic [DATA_W-1:0]                     beat_t;
    typedef logic [7:0]                            burst_len_t;
    typedef logic [$clog2(BEATS_PER_TILE)-1:0]     beat_idx_t;
    typedef logic [$clog2(NUM_TILE_H)-1:0]         h_idx_t;
    typedef logic [$clog2(NUM_TILE_P)-1:0]         p_idx_t;

    // ==================================================================
    // channel payloads
    // ==================================================================
    // shared by AR and AW
    typedef struct packed {
        addr_t      addr;
        burst_len_t len;
    } axi_addr_t;

    typedef struct packed {
        beat_t data;
        logic  last;
    } axi_r_t;

    typedef struct packed {
        beat_t data;
        logic  last;
    } axi_w_t;

    // reader to tile buffer
    typedef struct packed {
        logic      en;
        beat_idx_t idx;
        beat_t     data;
    } buf_wr_t;

    // state encodings
    typedef enum logic [2:0] {SEQ_IDLE, SEQ_READ, SEQ_WRITE, SEQ_NEXT, SEQ_DONE} seq_state_t;
    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_t;
    typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_t;

endpackage

// File: verilog/tile_sequencer.sv
// ======================================================================
// tile sequencer
// walks the tile grid h-major, forms the x and y burst addresses and
// orders read, write and the final done pulse, one tile at a time
// ======================================================================
`timescale 1ns/100ps

module tile_sequencer (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  packing_pkg::addr_t base_x,
    input  packing_pkg::addr_t base_y,
    input  logic               rd_done,
    input  logic               wr_done,
    output logic               rd_start,
    output logic               wr_start,
    output packing_pkg::addr_t rd_addr,
    output packing_pkg::addr_t wr_addr,
    output logic               done
);

    packing_pkg::seq_state_t state;
    packing_pkg::h_idx_t     h_idx;
    packing_pkg::p_idx_t     p_idx;
    packing_pkg::addr_t      tile_off;
    logic                    last_p;
    logic                    last_tile;

    // ==================================================================
    // address generation
    // ==================================================================
    // tile-major layout, tile k at base + k * TILE_BYTES
    assign tile_off = (packing_pkg::addr_t'(h_idx) * packing_pkg::NUM_TILE_P
                      + packing_pkg::addr_t'(p_idx)) * packing_pkg::TILE_BYTES;

    assign rd_addr = base_x + tile_off;
    assign wr_addr = base_y + tile_off;

    assign last_p    = (p_idx == packing_pkg::p_idx_t'(packing_pkg::NUM_TILE_P - 1));
    assign last_tile = last_p &&
                       (h_idx == packing_pkg::h_idx_t'(packing_pkg::NUM_TILE_H - 1));

    // ==================================================================
    // control FSM
    // ==================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= packing_pkg::SEQ_IDLE;
            h_idx    <= '0;
            p_idx    <= '0;
            rd_start <= 1'b0;
            wr_start <= 1'b0;
            done     <= 1'b0;
        end else begin
            // strobes are one cycle wide
            rd_start <= 1'b0;
            wr_start <= 1'b0;
            done     <= 1'b0;
            case (state)
                packing_pkg::SEQ_IDLE: begin
                    if (start) begin
                        h_idx    <= '0;
                        p_idx    <= '0;
                        rd_start <= 1'b1;
                        state    <= packing_pkg::SEQ_READ;
                    end
                end
                packing_pkg::SEQ_READ: begin
                    if (rd_done) begin
                        wr_start <= 1'b1;
                        state    <= packing_pkg::SEQ_WRITE;
                    end
                end
                packing_pkg::SEQ_WRITE: begin
                    if (wr_done) begin
                        state <= packing_pkg::SEQ_NEXT;
                    end
                end
                packing_pkg::SEQ_NEXT: begin
                    if (last_tile) begin
                        done  <= 1'b1;
                        state <= packing_pkg::SEQ_DONE;
                    end else begin
                        // p steps fastest and wraps into h
                        if (last_p) begin
                            p_idx <= '0;
                            h_idx <= h_idx + 1'b1;
                        end else begin
                            p_idx <= p_idx + 1'b1;
                        end
                        rd_start <= 1'b1;
                        state    <= packing_pkg::SEQ_READ;
                    end
                end
                packing_pkg::SEQ_DONE: begin
                    state <= packing_pkg::SEQ_IDLE;
                end
                default: begin
                    state <= packing_pkg::SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

// File: verilog/axi_tile_reader.sv
// ======================================================================
// AXI read burst engine
// issues one INCR read burst per tile and writes every accepted
// R beat into the tile buffer at the running beat index
// ======================================================================
`timescale 1ns/100ps

module axi_tile_reader (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rd_start,
    input  packing_pkg::addr_t     rd_addr,
    output packing_pkg::axi_addr_t ar,
    output logic                   ar_valid,
    input  logic                   ar_ready,
    input  packing_pkg::axi_r_t    r,
    input  logic                   r_valid,
    output logic                   r_ready,
    output packing_pkg::buf_wr_t   buf_wr,
    output logic                   rd_done
);

    packing_pkg::rd_state_t state;
    packing_pkg::beat_idx_t beat_idx;
    logic                   r_fire;

    // ==================================================================
    // handshake outputs
    // ==================================================================
    // valid and ready follow the state directly
    assign ar_valid = (state == packing_pkg::RD_ADDR);
    assign r_ready  = (state == packing_pkg::RD_DATA);

    assign r_fire  = r_valid && r_ready;
    assign rd_done = r_fire && r.last;

    // accepted beats go straight to the buffer
    always_comb begin
        buf_wr.en   = r_fire;
        buf_wr.idx  = beat_idx;
        buf_wr.data = r.data;
    end

    // AR payload, held from rd_start until the handshake
    always_ff @(posedge clk) begin
        if (rd_start && (state == packing_pkg::RD_IDLE)) begin
            ar.addr <= rd_addr;
            ar.len  <= packing_pkg::burst_len_t'(packing_pkg::BURST_LEN);
        end
    end

    // ==================================================================
    // burst FSM
    // ==================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= packing_pkg::RD_IDLE;
            beat_idx <= '0;
        end else begin
            case (state)
                packing_pkg::RD_IDLE: begin
                    if (rd_start) begin
                        state <= packing_pkg::RD_ADDR;
                    end
                end
                packing_pkg::RD_ADDR: begin
                    if (ar_ready) begin
                        beat_idx <= '0;
                        state    <= packing_pkg::RD_DATA;
                    end
                end
                packing_pkg::RD_DATA: begin
                    // a low r_valid just pauses the index
                    if (r_fire) begin
                        beat_idx <= beat_idx + 1'b1;
                        if (r.last) begin
                            state <= packing_pkg::RD_IDLE;
                        end
                    end
                end
                default: begin
                    state <= packing_pkg::RD_IDLE;
                end
            endcase
        end
    end

endmodule

// File: verilog/tile_buffer.sv
// ======================================================================
// tile buffer
// one tile of beats, clocked write from the reader and a
// combinational read for the writer
// ======================================================================
`timescale 1ns/100ps

module tile_buffer (
    input  logic                   clk,
    input  packing_pkg::buf_wr_t   buf_wr,
    input  packing_pkg::beat_idx_t rd_idx,
    output packing_pkg::beat_t     rd_beat
);

    // ==================================================================
    // storage
    // ==================================================================
    // one entry per beat of the tile
    packing_pkg::beat_t mem [0:packing_pkg::BEATS_PER_TILE-1];

    // write port
    always_ff @(posedge clk) begin
        if (buf_wr.en) begin
            mem[buf_wr.idx] <= buf_wr.data;
        end
    end

    // read port, beat is visible in the same cycle
    // as the index from the writer
    assign rd_beat = mem[rd_idx];

endmodule

// File: verilog/axi_tile_writer.sv
// ======================================================================
// AXI write burst engine
// issues one INCR write burst per tile, streams the buffer beats on
// W with last on the final beat and closes with the B handshake
// ======================================================================
`timescale 1ns/100ps

module axi_tile_writer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wr_start,
    input  packing_pkg::addr_t     wr_addr,
    output packing_pkg::beat_idx_t rd_idx,
    input  packing_pkg::beat_t     rd_beat,
    output packing_pkg::axi_addr_t aw,
    output logic                   aw_valid,
    input  logic                   aw_ready,
    output packing_pkg::axi_w_t    w,
    output logic                   w_valid,
    input  logic                   w_ready,
    input  logic                   b_valid,
    output logic                   b_ready,
    output logic                   wr_done
);

    packing_pkg::wr_state_t state;
    packing_pkg::beat_idx_t beat_idx;
    logic                   last_beat;
    logic                   w_fire;

    // ==================================================================
    // handshake outputs
    // ==================================================================
    assign aw_valid = (state == packing_pkg::WR_ADDR);
    assign w_valid  = (state == packing_pkg::WR_DATA);
    assign b_ready  = (state == packing_pkg::WR_RESP);

    assign last_beat = (beat_idx == packing_pkg::beat_idx_t'(packing_pkg::BURST_LEN));
    assign w_fire    = w_valid && w_ready;
    assign wr_done   = b_valid && b_ready;

    // buffer is addressed by the running beat index
    assign rd_idx = beat_idx;

    // W payload tracks the current buffer beat
    always_comb begin
        w.data = rd_beat;
        w.last = last_beat;
    end

    // AW payload, held until the handshake
    always_ff @(posedge clk) begin
        if (wr_start && (state == packing_pkg::WR_IDLE)) begin
            aw.addr <= wr_addr;
            aw.len  <= packing_pkg::burst_len_t'(packing_pkg::BURST_LEN);
        end
    end

    // ==================================================================
    // burst FSM
    // ==================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= packing_pkg::WR_IDLE;
            beat_idx <= '0;
        end else begin
            case (state)
                packing_pkg::WR_IDLE: begin
                    if (wr_start) begin
                        beat_idx <= '0;
                        state    <= packing_pkg::WR_ADDR;
                    end
                end
                packing_pkg::WR_ADDR: begin
                    if (aw_ready) begin
                        state <= packing_pkg::WR_DATA;
                    end
                end
                packing_pkg::WR_DATA: begin
                    // advance only on an accepted beat
                    if (w_fire) begin
                        if (last_beat) begin
                            state <= packing_pkg::WR_RESP;
                        end else begin
                            beat_idx <= beat_idx + 1'b1;
                        end
                    end
                end
                packing_pkg::WR_RESP: begin
                    // response code is not checked
                    if (b_valid) begin
                        state <= packing_pkg::WR_IDLE;
                    end
                end
                default: begin
                    state <= packing_pkg::WR_IDLE;
                end
            endcase
        end
    end

endmodule

// File: verilog/packing_axi_top.sv
// ======================================================================
// tile mover top level
// copies the x activation grid to y tile by tile over one AXI4
// master port, one tile in flight at a time
// ======================================================================
`timescale 1ns/100ps

module packing_axi_top (
    input  logic                   clk,
    input  logic                   rst,

    // control
    input  logic                   start,
    output logic                   done,
    input  packing_pkg::addr_t     base_x,
    input  packing_pkg::addr_t     base_y,

    // read address and data
    output packing_pkg::axi_addr_t ar,
    output logic                   ar_valid,
    input  logic                   ar_ready,
    input  packing_pkg::axi_r_t    r,
    input  logic                   r_valid,
    output logic                   r_ready,

    // write address, data and response
    output packing_pkg::axi_addr_t aw,
    output logic                   aw_valid,
    input  logic                   aw_ready,
    output packing_pkg::axi_w_t    w,
    output logic                   w_valid,
    input  logic                   w_ready,
    input  logic                   b_valid,
    output logic                   b_ready
);

    // sequencer to engines
    logic                   rd_start;
    logic                   rd_done;
    logic                   wr_start;
    logic                   wr_done;
    packing_pkg::addr_t     rd_addr;
    packing_pkg::addr_t     wr_addr;

    // buffer ports
    packing_pkg::buf_wr_t   buf_wr;
    packing_pkg::beat_idx_t rd_idx;
    packing_pkg::beat_t     rd_beat;

    // ==================================================================
    // decode, tile walk and addresses
    // ==================================================================
    tile_sequencer u_tile_sequencer (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .base_x   (base_x),
        .base_y   (base_y),
        .rd_done  (rd_done),
        .wr_done  (wr_done),
        .rd_start (rd_start),
        .wr_start (wr_start),
        .rd_addr  (rd_addr),
        .wr_addr  (wr_addr),
        .done     (done)
    );

    // ==================================================================
    // execute, read burst into the buffer
    // ==================================================================
    axi_tile_reader u_axi_tile_reader (
        .clk      (clk),
        .rst      (rst),
        .rd_start (rd_start),
        .rd_addr  (rd_addr),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .buf_wr   (buf_wr),
        .rd_done  (rd_done)
    );

    tile_buffer u_tile_buffer (
        .clk     (clk),
        .buf_wr  (buf_wr),
        .rd_idx  (rd_idx),
        .rd_beat (rd_beat)
    );

    // ==================================================================
    // result, write burst from the buffer
    // ==================================================================
    axi_tile_writer u_axi_tile_writer (
        .clk      (clk),
        .rst      (rst),
        .wr_start (wr_start),
        .wr_addr  (wr_addr),
        .rd_idx   (rd_idx),
        .rd_beat  (rd_beat),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .wr_done  (wr_done)
    );

endmodule

// File: tb/axi_mem_model.sv
// ======================================================================
// AXI slave memory model
// sparse 16-bit word memory serving one read and one write burst at a
// time, with optional random ready stalls and a log of every AR and AW
// ======================================================================
`timescale 1ns/100ps

module axi_mem_model (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  packing_pkg::axi_addr_t ar,
    input  logic                   ar_valid,
    output logic                   ar_ready,
    output packing_pkg::axi_r_t    r,
    output logic                   r_valid,
    input  logic                   r_ready,
    input  packing_pkg::axi_addr_t aw,
    input  logic                   aw_valid,
    output logic                   aw_ready,
    input  packing_pkg::axi_w_t    w,
    input  logic                   w_valid,
    output logic                   w_ready,
    output logic                   b_valid,
    input  logic                   b_ready
);

    // keyed by the byte address of each 16-bit word
    logic [15:0] mem [packing_pkg::addr_t];

    packing_pkg::axi_addr_t ar_log [$];
    packing_pkg::axi_addr_t aw_log [$];

    integer seed = 32'h58d39dfe;

    // burst progress
    logic               rd_busy;
    packing_pkg::addr_t rd_ptr;
    int                 rd_left;
    logic               wr_busy;
    packing_pkg::addr_t wr_ptr;
    logic               b_pend;
    logic               r_hold;
    logic               b_hold;

    // ==================================================================
    // access from the testbench
    // ==================================================================
    function automatic logic [15:0] peek(input packing_pkg::addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return 16'h0000;
    endfunction

    task automatic poke(input packing_pkg::addr_t a, input logic [15:0] v);
        mem[a] = v;
    endtask

    task automatic clear_logs();
        ar_log.delete();
        aw_log.delete();
    endtask

    function automatic int log_size(input logic is_write);
        return is_write ? aw_log.size() : ar_log.size();
    endfunction

    function automatic packing_pkg::axi_addr_t log_entry(input logic is_write, input int k);
        return is_write ? aw_log[k] : ar_log[k];
    endfunction

    // roughly one cycle in four is dropped while stalling
    function automatic logic go();
        integer roll;
        roll = $random(seed);
        return !stall || (roll[1:0] != 2'b00);
    endfunction

    function automatic packing_pkg::beat_t read_beat(input packing_pkg::addr_t a);
        packing_pkg::beat_t b;
        for (int j = 0; j < packing_pkg::WORDS_PER_BEAT; j++) begin
            b[j*16 +: 16] = peek(a + packing_pkg::addr_t'(2 * j));
        end
        return b;
    endfunction

    // ==================================================================
    // slave channels
    // ==================================================================
    initial begin
        ar_ready = 1'b0;
        r        = '0;
        r_valid  = 1'b0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        rd_busy  = 1'b0;
        rd_ptr   = '0;
        rd_left  = 0;
        wr_busy  = 1'b0;
        wr_ptr   = '0;
        b_pend   = 1'b0;
        forever begin
            @(posedge clk);
            // a valid not yet taken stays up with its payload
            r_hold = r_valid && !r_ready;
            b_hold = b_valid && !b_ready;
            if (rst) begin
                rd_busy = 1'b0;
                wr_busy = 1'b0;
                b_pend  = 1'b0;
                r_hold  = 1'b0;
                b_hold  = 1'b0;
            end else begin
                if (ar_valid && ar_ready) begin
                    ar_log.push_back(ar);
                    rd_busy = 1'b1;
                    rd_ptr  = ar.addr;
                    rd_left = int'(ar.len) + 1;
                end
                if (r_valid && r_ready) begin
                    rd_ptr  = rd_ptr + 64'd16;
                    rd_left = rd_left - 1;
                    rd_busy = (rd_left != 0);
                end
                if (aw_valid && aw_ready) begin
                    aw_log.push_back(aw);
                    wr_busy = 1'b1;
                    wr_ptr  = aw.addr;
                end
                // full-width beats, every strobe set
                if (w_valid && w_ready) begin
                    for (int j = 0; j < packing_pkg::WORDS_PER_BEAT; j++) begin
                        mem[wr_ptr + packing_pkg::addr_t'(2 * j)] = w.data[j*16 +: 16];
                    end
                    wr_ptr = wr_ptr + 64'd16;
                    if (w.last) begin
                        b_pend = 1'b1;
                    end
                end
                if (b_valid && b_ready) begin
                    b_pend  = 1'b0;
                    wr_busy = 1'b0;
                end
            end
            // outputs move 2 ns after the edge
            #2;
            ar_ready = !rst && !rd_busy && go();
            r_valid  = r_hold || (!rst && rd_busy && go());
            r.data   = read_beat(rd_ptr);
            r.last   = (rd_left == 1);
            aw_ready = !rst && !wr_busy && go();
            w_ready  = !rst && wr_busy && !b_pend && go();
            b_valid  = b_hold || (!rst && b_pend && go());
        end
    end

endmodule

// File: tb/tb_packing_axi_top.sv
// ======================================================================
// tile mover testbench
// runs a table of grid copies through the DUT against the AXI memory
// model and checks data, burst addresses and lengths and done
// ======================================================================
`timescale 1ns/100ps

module tb_packing_axi_top;

    logic                   clk;
    logic                   rst;
    logic                   start;
    logic                   stall;
    logic                   done;
    packing_pkg::addr_t     base_x;
    packing_pkg::addr_t     base_y;
    packing_pkg::axi_addr_t ar;
    logic                   ar_valid;
    logic                   ar_ready;
    packing_pkg::axi_r_t    r;
    logic                   r_valid;
    logic                   r_ready;
    packing_pkg::axi_addr_t aw;
    logic                   aw_valid;
    logic                   aw_ready;
    packing_pkg::axi_w_t    w;
    logic                   w_valid;
    logic                   w_ready;
    logic                   b_valid;
    logic                   b_ready;

    // stimulus table, one row per run
    string              row_name   [3] = '{"plain_copy", "stalled_copy", "restart_copy"};
    packing_pkg::addr_t row_base_x [3] = '{64'h0000_0000_0000_1000,
                                           64'h0000_0001_0000_0000,
                                           64'h0000_0000_0002_0000};
    packing_pkg::addr_t row_base_y [3] = '{64'h0000_0000_0000_8000,
                                           64'h0000_0001_0004_0000,
                                           64'h0000_0000_0000_1000};
    logic               row_stall  [3] = '{1'b0, 1'b1, 1'b1};

    string cur_name;
    int    errors     = 0;
    int    row_errors = 0;
    int    tests      = 0;
    int    failed     = 0;
    logic  timed_out  = 1'b0;

    // running counts kept by the monitor
    int    done_count = 0;
    int    long_done  = 0;
    int    b_count    = 0;
    int    b_at_done  = 0;
    logic  done_prev  = 1'b0;

    // port names match on both sides
    packing_axi_top u_packing_axi_top (.*);
    axi_mem_model   u_axi_mem_model (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==================================================================
    // monitor
    // ==================================================================
    // handshakes seen here complete on the next rising edge
    always @(negedge clk) begin
        if (b_valid && b_ready) begin
            b_count = b_count + 1;
        end
        if (done) begin
            done_count = done_count + 1;
            b_at_done  = b_count;
            if (done_prev) begin
                long_done = long_done + 1;
            end
        end
        done_prev = done;
    end

    // ==================================================================
    // compare tasks
    // ==================================================================
    task automatic check_beat(input string what, input packing_pkg::beat_t exp,
                              input packing_pkg::beat_t act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %h actual %h", cur_name, what, exp, act);
            row_errors++;
        end
    endtask

    task automatic check_addr(input string what, input packing_pkg::addr_t exp,
                              input packing_pkg::addr_t act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %h actual %h", cur_name, what, exp, act);
            row_errors++;
        end
    endtask

    task automatic check_len(input string what, input packing_pkg::burst_len_t exp,
                             input packing_pkg::burst_len_t act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %0d actual %0d", cur_name, what, exp, act);
            row_errors++;
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("mismatch %s %s: expected %0d actual %0d", cur_name, what, exp, act);
            row_errors++;
        end
    endtask

    // ==================================================================
    // test steps
    // ==================================================================
    task automatic finish_test();
        tests++;
        errors = errors + row_errors;
        if (row_errors == 0) begin
            $display("test %s: ok", cur_name);
        end else begin
            $display("test %s: %0d errors", cur_name, row_errors);
            failed++;
        end
    endtask

    // bursts go out h-major, tile k at base + k tiles of 384 bytes
    task automatic check_bursts(input logic is_write, input packing_pkg::addr_t base);
        packing_pkg::axi_addr_t entry;
        string                  kind;
        int                     n;
        kind = is_write ? "write" : "read";
        n    = u_axi_mem_model.log_size(is_write);
        check_count({kind, " bursts"}, 8, n);
        for (int k = 0; k < n && k < 8; k++) begin
            entry = u_axi_mem_model.log_entry(is_write, k);
            check_addr($sformatf("%s burst %0d address", kind, k),
                       base + packing_pkg::addr_t'(k * 384), entry.addr);
            check_len($sformatf("%s burst %0d length", kind, k), 8'd23, entry.len);
        end
    endtask

    task automatic run_row(input int row);
        int                 done0;
        int                 long0;
        int                 b0;
        int                 cycles;
        packing_pkg::addr_t off;
        packing_pkg::beat_t exp;
        packing_pkg::beat_t act;
        cur_name   = row_name[row];
        row_errors = 0;
        // source words count up from the row number
        for (int i = 0; i < 8 * 192; i++) begin
            off = packing_pkg::addr_t'(2 * i);
            u_axi_mem_model.poke(row_base_x[row] + off, 16'(i + row));
            u_axi_mem_model.poke(row_base_y[row] + off, 16'h0000);
        end
        u_axi_mem_model.clear_logs();
        done0 = done_count;
        long0 = long_done;
        b0    = b_count;

        @(posedge clk);
        #1;
        base_x = row_base_x[row];
        base_y = row_base_y[row];
        stall  = row_stall[row];
        start  = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;

        cycles = 0;
        while (done_count == done0 && cycles < 20000) begin
            @(negedge clk);
            cycles++;
        end
        if (done_count == done0) begin
            $display("test %s: timed out waiting for done", cur_name);
            timed_out = 1'b1;
            row_errors++;
        end else begin
            // a stray second done would land in this window
            repeat (10) @(negedge clk);
            check_count("done pulses", 1, done_count - done0);
            check_count("done pulses wider than one cycle", 0, long_done - long0);
            check_count("write responses before done", 8, b_at_done - b0);
            check_bursts(1'b0, row_base_x[row]);
            check_bursts(1'b1, row_base_y[row]);
            // y is a copy of x
            for (int b = 0; b < 8 * 24; b++) begin
                for (int j = 0; j < 8; j++) begin
                    off = packing_pkg::addr_t'(2 * (b * 8 + j));
                    exp[j*16 +: 16] = 16'(b * 8 + j + row);
                    act[j*16 +: 16] = u_axi_mem_model.peek(row_base_y[row] + off);
                end
                check_beat($sformatf("destination beat %0d", b), exp, act);
            end
        end
        finish_test();
    endtask

    // ==================================================================
    // main sequence
    // ==================================================================
    initial begin
        rst    = 1'b1;
        start  = 1'b0;
        stall  = 1'b0;
        base_x = '0;
        base_y = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        cur_name   = "reset_idle";
        row_errors = 0;
        @(negedge clk);
        if (ar_valid || r_ready || aw_valid || w_valid || b_ready || done) begin
            $display("a valid, ready or done output is high after reset");
            row_errors++;
        end
        finish_test();

        for (int row = 0; row < 3; row++) begin
            run_row(row);
            if (timed_out) begin
                break;
            end
        end

        $display("summary: %0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: packing_axi_top.f
verilog/packing_pkg.sv
verilog/tile_sequencer.sv
verilog/axi_tile_reader.sv
verilog/tile_buffer.sv
verilog/axi_tile_writer.sv
verilog/packing_axi_top.sv
tb/axi_mem_model.sv
tb/tb_packing_axi_top.sv

// File: Makefile
TOP = tb_packing_axi_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -j 0 --top-module $(TOP) -f packing_axi_top.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
